/* rtl/sdram_timing_pkg.sv */
////////////////////////////////////////
// SDRAM timing package.
// Minimum command gaps, ack delays and counter types
// for the controller's safety counters.
////////////////////////////////////////

package sdram_timing_pkg;

	typedef logic [2:0] safe_cnt_t;	// Safety and bank-timer down-counters.
	typedef logic [1:0] tim_wr_t;	// Extra write-recovery cycles, 0 to 3.

	// All gaps are in sys_clk cycles, measured from command to command on cmd.
	localparam int burst_cycles      = 4;	// Transfers in one burst.
	localparam int rd_to_rd_gap      = 4;
	localparam int wr_to_rd_gap      = 5;	// Four transfers plus tWTR.
	localparam int rd_to_wr_gap_base = 5;	// tim_cas is added on top.
	localparam int wr_to_wr_gap      = 4;
	localparam int rd_to_pre_gap     = 4;
	localparam int wr_to_pre_base    = 5;	// tim_wr is added on top.
	localparam int act_to_rw_gap     = 2;	// tRCD.
	localparam int pre_to_act_gap    = 2;	// tRP.

	// A write is acknowledged to the scheduler this many cycles after the command.
	localparam int wr_ack_delay = 2;
	// A read needs rd_ack_base plus tim_cas cycles.
	localparam int rd_ack_base  = 5;
	// Read-only stages in front of the shared write stages, with tim_cas high.
	localparam int rd_ack_stages = rd_ack_base + 1 - wr_ack_delay;

	// Cycles from a write command to the first cycle with the bus turned around.
	localparam int dir_delay = 2;

	// A safe flag counter is loaded with its gap minus this bias.
	// One cycle is lost to the load, one to the scheduler's command register.
	localparam int cnt_bias = 2;

endpackage

/* rtl/sdram_cmd_pkg.sv */
////////////////////////////////////////
// SDRAM command package.
// Address fields, command encoding and scheduler states.
////////////////////////////////////////

package sdram_cmd_pkg;

	localparam int num_banks = 4;

	typedef logic [1:0]           bank_t;
	typedef logic [num_banks-1:0] bank_mask_t;	// One bit per bank, one hot when used.
	typedef logic [12:0]          row_t;
	typedef logic [9:0]           col_t;

	// Encoded as {ras_n, cas_n, we_n} with chip select held low.
	typedef enum logic [2:0] {
		cmd_nop       = 3'b111,
		cmd_activate  = 3'b011,
		cmd_read      = 3'b101,
		cmd_write     = 3'b100,
		cmd_precharge = 3'b010
	} sdram_cmd_e;

	typedef enum logic [2:0] {
		st_idle,
		st_precharge_wait,
		st_activate_wait,
		st_rw_wait,
		st_data_wait,
		st_release
	} sched_state_e;

endpackage

/* rtl/sdram_data_if.sv */
////////////////////////////////////////
// Scheduler to data controller link.
// Read/write pulses go one way, safe flags
// and the access-done pulse come back.
////////////////////////////////////////

`timescale 1ns/1ps

interface sdram_data_if
	import sdram_cmd_pkg::*;
();

	logic       read;		// One cycle, with the read command on cmd.
	logic       write;		// One cycle, with the write command on cmd.
	bank_mask_t concerned_bank;	// Valid only while read or write is high.
	logic       read_safe;
	logic       write_safe;
	bank_mask_t precharge_safe;	// One flag per bank.
	logic       data_ack;		// End of the data phase of the access.

	modport sched (
		output read, write, concerned_bank,
		input  read_safe, write_safe, precharge_safe, data_ack
	);

	modport datactl (
		input  read, write, concerned_bank,
		output read_safe, write_safe, precharge_safe, data_ack
	);

endinterface

/* rtl/sdram_bank_timer.sv */
////////////////////////////////////////
// Bank precharge timer.
// Holds off a precharge until the bank's
// last read or write has finished.
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_bank_timer
	import sdram_timing_pkg::*;
(
	input  logic    sys_clk,
	input  logic    sdram_rst,
	input  logic    read,
	input  logic    write,
	input  logic    tim_cas,
	input  tim_wr_t tim_wr,
	output logic    precharge_safe
);

	safe_cnt_t pre_cnt;	// Cycles left before a precharge may be registered.

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			pre_cnt <= '0;
		end else if (read) begin
			// A read burst may be cut by a precharge once its transfers are out.
			pre_cnt <= safe_cnt_t'(rd_to_pre_gap - cnt_bias);
		end else if (write) begin
			// Writes also need the write recovery time after the last transfer.
			pre_cnt <= safe_cnt_t'(wr_to_pre_base - cnt_bias) + safe_cnt_t'(tim_wr);
		end else if (pre_cnt != '0) begin
			pre_cnt <= pre_cnt - 1'b1;
		end
	end

	assign precharge_safe = (pre_cnt == '0);	// Idle counter means the bank is free.

	// The scheduler sends one command at a time, so a bank never sees both.
	a_single_access: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		!(read && write))
		else $error("Read and write reached bank timer together.");

	// The timing setup is static configuration.
	// It must not move while a recovery is still counting.
	a_static_config: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		!$stable({tim_cas, tim_wr}) |-> precharge_safe)
		else $error("Timing configuration changed during bank recovery.");

endmodule

/* rtl/sdram_data_ctl.sv */
////////////////////////////////////////
// SDRAM data controller.
// Read/write safe flags, the access-done pulse,
// the data bus direction and the bank timers.
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_data_ctl
	import sdram_timing_pkg::*;
	import sdram_cmd_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sdram_rst,
	sdram_data_if.datactl        dif,
	input  logic                 tim_cas,
	input  tim_wr_t              tim_wr,
	output logic                 direction
);

	safe_cnt_t rd_cnt;			// Cycles until a read may be registered.
	safe_cnt_t wr_cnt;			// Cycles until a write may be registered.
	logic [rd_ack_stages-1:0] rd_pipe;	// Read-only part of the ack delay line.
	logic [wr_ack_delay-1:0]  ack_pipe;	// Shared tail, fed by reads and writes.
	safe_cnt_t dir_cnt;			// Remaining cycles of the write window.
	logic      dir_win;			// Write window before the output delay.
	logic [dir_delay-1:0]     dir_pipe;	// Delays the window onto the bus timing.

	// Both flags are reloaded on every read or write.
	// A later command simply restarts the gap from its own issue cycle.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			rd_cnt <= '0;
			wr_cnt <= '0;
		end else if (dif.read) begin
			rd_cnt <= safe_cnt_t'(rd_to_rd_gap - cnt_bias);
			// Read data must have cleared the bus before a write drives it.
			wr_cnt <= safe_cnt_t'(rd_to_wr_gap_base - cnt_bias) + safe_cnt_t'(tim_cas);
		end else if (dif.write) begin
			rd_cnt <= safe_cnt_t'(wr_to_rd_gap - cnt_bias);	// Burst plus tWTR.
			wr_cnt <= safe_cnt_t'(wr_to_wr_gap - cnt_bias);
		end else begin
			if (rd_cnt != '0)
				rd_cnt <= rd_cnt - 1'b1;
			if (wr_cnt != '0)
				wr_cnt <= wr_cnt - 1'b1;
		end
	end

	assign dif.read_safe  = (rd_cnt == '0);
	assign dif.write_safe = (wr_cnt == '0);

	// The read path enters one stage further up when CAS latency is 3.
	// The pipe can hold a read and a later write at once, so stages are ORed.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			rd_pipe  <= '0;
			ack_pipe <= '0;
		end else begin
			rd_pipe <= {dif.read & tim_cas, rd_pipe[rd_ack_stages-1:1]};
			if (!tim_cas)
				rd_pipe[rd_ack_stages-2] <= dif.read;	// Skip the top stage.
			ack_pipe <= {rd_pipe[0] | dif.write, ack_pipe[wr_ack_delay-1:1]};
		end
	end

	assign dif.data_ack = ack_pipe[0];	// One cycle per access.

	// The window lasts one burst from the write command.
	// A new write restarts it.
	assign dir_win = dif.write || (dir_cnt != '0);

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			dir_cnt  <= '0;
			dir_pipe <= '0;
		end else begin
			if (dif.write)
				dir_cnt <= safe_cnt_t'(burst_cycles - 1);
			else if (dir_cnt != '0)
				dir_cnt <= dir_cnt - 1'b1;
			dir_pipe <= {dir_win, dir_pipe[dir_delay-1:1]};	// Line up with write data.
		end
	end

	assign direction = !dir_pipe[0];	// Low while the controller drives the bus.

	// One timer per bank, each seeing only the accesses to its own bank.
	for (genvar i = 0; i < num_banks; i++) begin : g_bank
		sdram_bank_timer u_bank_timer (
			.sys_clk       (sys_clk),
			.sdram_rst     (sdram_rst),
			.read          (dif.read & dif.concerned_bank[i]),
			.write         (dif.write & dif.concerned_bank[i]),
			.tim_cas       (tim_cas),
			.tim_wr        (tim_wr),
			.precharge_safe(dif.precharge_safe[i])
		);
	end

	// The scheduler must honour the flags this block hands out.
	a_rw_safe: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		(dif.read -> dif.read_safe) && (dif.write -> dif.write_safe))
		else $error("Read or write issued while its safe flag was low.");

endmodule

/* rtl/sdram_cmd_sched.sv */
////////////////////////////////////////
// SDRAM command scheduler.
// Host handshake, open-row tracking and the
// precharge/activate/read/write sequencing.
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_cmd_sched
	import sdram_timing_pkg::*;
	import sdram_cmd_pkg::*;
(
	input  logic         sys_clk,
	input  logic         sdram_rst,
	input  logic         req,
	input  logic         we,
	input  bank_t        bank,
	input  row_t         row,
	input  col_t         col,
	output logic         ack,
	output sdram_cmd_e   cmd,
	output bank_t        cmd_bank,
	output row_t         cmd_addr,
	sdram_data_if.sched  dif
);

	sched_state_e state;
	bank_mask_t   row_open;			// Bank has an activated row.
	row_t         open_row [num_banks];	// Which row, valid when row_open is set.
	safe_cnt_t    wait_cnt;			// tRP and tRCD countdown.
	logic         row_hit;
	logic         rw_safe;

	// Request fields are stable from req rising until ack, so they are used directly.
	assign row_hit = row_open[bank] && (open_row[bank] == row);
	assign rw_safe = we ? dif.write_safe : dif.read_safe;

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			state     <= st_idle;
			row_open  <= '0;
			wait_cnt  <= '0;
			ack       <= 1'b0;
			cmd       <= cmd_nop;
			dif.read  <= 1'b0;
			dif.write <= 1'b0;
		end else begin
			// Commands and the data pulses last one cycle.
			cmd       <= cmd_nop;
			dif.read  <= 1'b0;
			dif.write <= 1'b0;
			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;

			case (state)
				st_idle: begin
					if (req) begin
						if (row_hit)
							state <= st_rw_wait;		// Row already open.
						else if (row_open[bank])
							state <= st_precharge_wait;	// Another row is in the way.
						else
							state <= st_activate_wait;
					end
				end
				st_precharge_wait: begin
					// The bank timer covers the last burst and write recovery.
					if (dif.precharge_safe[bank]) begin
						cmd            <= cmd_precharge;
						cmd_bank       <= bank;
						cmd_addr       <= '0;		// A10 low, this bank only.
						row_open[bank] <= 1'b0;
						wait_cnt       <= safe_cnt_t'(pre_to_act_gap - 1);
						state          <= st_activate_wait;
					end
				end
				st_activate_wait: begin
					if (wait_cnt == '0) begin
						cmd            <= cmd_activate;
						cmd_bank       <= bank;
						cmd_addr       <= row;
						row_open[bank] <= 1'b1;
						open_row[bank] <= row;
						wait_cnt       <= safe_cnt_t'(act_to_rw_gap - 1);
						state          <= st_rw_wait;
					end
				end
				st_rw_wait: begin
					// tRCD first, then the turnaround flags from the data controller.
					if ((wait_cnt == '0) && rw_safe) begin
						cmd                <= we ? cmd_write : cmd_read;
						cmd_bank           <= bank;
						cmd_addr           <= row_t'(col);	// Column in the low bits.
						dif.read           <= !we;
						dif.write          <= we;
						dif.concerned_bank <= bank_mask_t'(1) << bank;
						state              <= st_data_wait;
					end
				end
				st_data_wait: begin
					if (dif.data_ack) begin
						ack   <= 1'b1;
						state <= st_release;
					end
				end
				st_release: begin
					// ack stays up until the host lets go of req.
					if (!req) begin
						ack   <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Four-phase rule on the host side.
	a_req_held: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		$fell(req) |-> ack)
		else $error("Host dropped req before ack.");

endmodule

/* rtl/sdram_ctl_top.sv */
////////////////////////////////////////
// SDRAM controller core, top level.
// Scheduler and data controller joined by
// the data interface.
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_ctl_top
	import sdram_timing_pkg::*;
	import sdram_cmd_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sdram_rst,
	input  logic       tim_cas,	// CAS latency 2 when low, 3 when high.
	input  tim_wr_t    tim_wr,
	input  logic       req,
	input  logic       we,
	input  bank_t      bank,
	input  row_t       row,
	input  col_t       col,
	output logic       ack,
	output sdram_cmd_e cmd,
	output bank_t      cmd_bank,
	output row_t       cmd_addr,
	output logic       direction
);

	sdram_data_if dif ();

	sdram_cmd_sched u_sched (
		.sys_clk  (sys_clk),
		.sdram_rst(sdram_rst),
		.req      (req),
		.we       (we),
		.bank     (bank),
		.row      (row),
		.col      (col),
		.ack      (ack),
		.cmd      (cmd),
		.cmd_bank (cmd_bank),
		.cmd_addr (cmd_addr),
		.dif      (dif)
	);

	sdram_data_ctl u_data_ctl (
		.sys_clk  (sys_clk),
		.sdram_rst(sdram_rst),
		.dif      (dif),
		.tim_cas  (tim_cas),
		.tim_wr   (tim_wr),
		.direction(direction)
	);

endmodule

/* tb/sdram_ctl_tests.svh */
////////////////////////////////////////
// Directed tests for the SDRAM controller.
// One task per behavior, run in order.
////////////////////////////////////////

	// Outputs rest while the host is quiet.
	task automatic idle_after_reset();
		repeat (20) begin
			@(negedge sys_clk);
			if (cmd !== cmd_nop)
				value_error($sformatf("cmd 0x%0h, expected 0x%0h", cmd, cmd_nop));
			if (ack !== 1'b0)
				value_error($sformatf("ack 0x%0h, expected 0x0", ack));
			if (direction !== 1'b1)
				value_error($sformatf("direction 0x%0h, expected 0x1", direction));
		end
	endtask

	// Activate then write, ack 3 cycles later, direction window checked by the monitor.
	task automatic write_closed_bank();
		set_timing(1'b0, 2'd0);
		host_access(1'b1, 2'd0, 13'h0123, 10'h045);
	endtask

	// Bank 0 still holds row 0x123 from the write test.
	task automatic read_open_row();
		host_access(1'b0, 2'd0, 13'h0123, 10'h046);	// CAS 2, ack after 6.
		set_timing(1'b1, 2'd0);
		host_access(1'b0, 2'd0, 13'h0123, 10'h047);	// CAS 3, ack after 7.
	endtask

	// Write to read and read to write on one row, with both CAS settings.
	task automatic bus_turnaround();
		int cas;
		for (cas = 0; cas < 2; cas++) begin
			set_timing(cas[0], 2'd1);
			host_access(1'b1, 2'd1, 13'h0010, 10'h100);
			host_access(1'b0, 2'd1, 13'h0010, 10'h104);
			host_access(1'b1, 2'd1, 13'h0010, 10'h108);
		end
	endtask

	// Row conflicts right behind a write, for every write-recovery setting.
	task automatic row_conflict();
		int w;
		for (w = 0; w < 4; w++) begin
			set_timing(1'b0, tim_wr_t'(w));
			host_access(1'b1, 2'd2, row_t'(13'h0200 + w), 10'h010);
			host_access(1'b1, 2'd2, row_t'(13'h1300 + w), 10'h020);
		end
		host_access(1'b0, 2'd2, 13'h0abc, 10'h030);
		host_access(1'b0, 2'd2, 13'h0abd, 10'h034);	// Conflict behind a read.
	endtask

	// Few rows per bank, so hits, misses and conflicts all occur.
	task automatic random_traffic();
		int i;
		for (i = 0; i < 80; i++) begin
			if (i % 20 == 0)
				set_timing(1'($urandom % 2), tim_wr_t'($urandom % 4));
			host_access(1'($urandom % 2), bank_t'($urandom % 4), row_t'($urandom % 3),
				col_t'($urandom));
		end
	endtask

/* tb/sdram_ctl_tb.sv */
////////////////////////////////////////
// SDRAM controller testbench.
// Host access driver, command monitor with
// the gap rules, timeout and final report.
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_ctl_tb
	import sdram_timing_pkg::*;
	import sdram_cmd_pkg::*;
();

	localparam int planned_accesses = 99;	// Sum of all accesses made by the tests.
	localparam int access_cycles    = 60;	// Generous bound for one full handshake.
	localparam int cycle_limit      = access_cycles * planned_accesses;
	localparam int never            = -1000;	// Cycle stamp of an event that has not happened.

	logic       sys_clk;
	logic       sdram_rst;
	logic       tim_cas;
	tim_wr_t    tim_wr;
	logic       req;
	logic       we;
	bank_t      bank;
	row_t       row;
	col_t       col;
	logic       ack;
	sdram_cmd_e cmd;
	bank_t      cmd_bank;
	row_t       cmd_addr;
	logic       direction;

	int cyc = 0;			// Rising edges since time zero.
	int n_value_err = 0;
	int n_rule_err = 0;
	int n_accesses = 0;
	logic in_access;		// High from req until ack has dropped again.

	// Monitor state, stamped with cyc at the negative edge.
	int      last_rd;
	int      last_rd_cas;		// tim_cas in force at the last read.
	int      last_wr;
	int      prev_wr;
	int      bank_rw [num_banks];
	logic    bank_rw_wr [num_banks];
	tim_wr_t bank_rw_twr [num_banks];
	int      bank_pre [num_banks];
	int      bank_act [num_banks];
	logic    mon_open [num_banks];
	row_t    mon_row [num_banks];
	int      pre_gap;
	logic    exp_dir;

	// What the monitor saw during the current access.
	int         n_pre;
	int         n_act;
	int         n_rw;
	int         rw_cyc;
	sdram_cmd_e rw_cmd;
	bank_t      rw_bank;
	row_t       rw_addr;
	row_t       act_row;

	// Rows that the host side expects to be open.
	logic pred_open [num_banks];
	row_t pred_row [num_banks];

	sdram_ctl_top dut_i (
		.sys_clk  (sys_clk),
		.sdram_rst(sdram_rst),
		.tim_cas  (tim_cas),
		.tim_wr   (tim_wr),
		.req      (req),
		.we       (we),
		.bank     (bank),
		.row      (row),
		.col      (col),
		.ack      (ack),
		.cmd      (cmd),
		.cmd_bank (cmd_bank),
		.cmd_addr (cmd_addr),
		.direction(direction)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;	// 4 ns period.
	end

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
		if (cyc >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic value_error(input string msg);
		n_value_err++;
		$display("error: %s at cycle %0d", msg, cyc);
	endtask

	task automatic rule_error(input string msg);
		n_rule_err++;
		$display("%s At cycle %0d.", msg, cyc);
	endtask

	// The bus is turned around for one burst, dir_delay cycles after a write.
	function automatic logic in_write_window(input int d);
		return (d >= dir_delay) && (d < dir_delay + burst_cycles);
	endfunction

	// One four-phase access, with the response checked against the row model.
	// It starts just after the rising edge where the caller left off.
	// Back to back accesses thus follow ack low as closely as the host may.
	task automatic host_access(input logic w, input bank_t b, input row_t r, input col_t c);
		int exp_pre;
		int exp_act;
		int exp_lat;
		int waited;
		exp_act = (!pred_open[b] || (pred_row[b] != r)) ? 1 : 0;
		exp_pre = (pred_open[b] && (pred_row[b] != r)) ? 1 : 0;
		exp_lat = w ? wr_ack_delay + 1 : rd_ack_base + int'(tim_cas) + 1;	// Plus ack register.
		n_pre = 0;
		n_act = 0;
		n_rw = 0;
		in_access = 1'b1;
		we = w;
		bank = b;
		row = r;
		col = c;
		req = 1'b1;
		waited = 0;
		do begin
			@(negedge sys_clk);
			waited++;
		end while (!ack && waited < access_cycles);
		if (!ack)
			rule_error("No ack came back within the access time limit.");
		if (n_rw != 1)
			value_error($sformatf("read/write count 0x%0h, expected 0x1", n_rw));
		if (cyc - rw_cyc != exp_lat)
			value_error($sformatf("ack latency 0x%0h, expected 0x%0h", cyc - rw_cyc, exp_lat));
		if (rw_cmd !== (w ? cmd_write : cmd_read))
			value_error($sformatf("cmd 0x%0h, expected 0x%0h", rw_cmd,
				w ? cmd_write : cmd_read));
		if (rw_bank !== b)
			value_error($sformatf("cmd_bank 0x%0h, expected 0x%0h", rw_bank, b));
		if (rw_addr !== row_t'(c))
			value_error($sformatf("cmd_addr 0x%0h, expected 0x%0h", rw_addr, c));
		if (n_pre != exp_pre)
			value_error($sformatf("precharge count 0x%0h, expected 0x%0h", n_pre, exp_pre));
		if (n_act != exp_act)
			value_error($sformatf("activate count 0x%0h, expected 0x%0h", n_act, exp_act));
		if (exp_act == 1 && act_row !== r)
			value_error($sformatf("cmd_addr 0x%0h on activate, expected 0x%0h", act_row, r));
		@(posedge sys_clk);
		#1;
		req = 1'b0;
		@(negedge sys_clk);	// The DUT has not seen req low yet.
		if (!ack)
			rule_error("ack fell before the DUT could see req low.");
		@(posedge sys_clk);	// The DUT sees req low here.
		#1;
		if (ack)
			rule_error("ack still high one cycle after req was seen low.");
		in_access = 1'b0;
		pred_open[b] = 1'b1;	// Every access leaves its row open.
		pred_row[b] = r;
		n_accesses++;
	endtask

	// Waits until every bank timer has run out, then changes the configuration.
	task automatic set_timing(input logic cas, input tim_wr_t wr);
		repeat (12) @(posedge sys_clk);
		#1;
		tim_cas = cas;
		tim_wr = wr;
	endtask

	// Command monitor. Outputs are stable at the falling edge.
	always @(negedge sys_clk) begin
		if (!sdram_rst) begin
			exp_dir = !(in_write_window(cyc - last_wr) || in_write_window(cyc - prev_wr));
			if (direction !== exp_dir)
				value_error($sformatf("direction 0x%0h, expected 0x%0h", direction, exp_dir));
			if (cmd !== cmd_nop && !in_access)
				rule_error("A command appeared with no access in flight.");
			if (cmd === cmd_read || cmd === cmd_write) begin
				if (cyc - bank_act[cmd_bank] < act_to_rw_gap)
					rule_error("Read or write came too soon after the activate.");
				if (!mon_open[cmd_bank] || mon_row[cmd_bank] !== row)
					rule_error("Read or write went to a row that is not open.");
				if (cmd === cmd_read) begin
					if (cyc - last_rd < rd_to_rd_gap)
						rule_error("Read came too soon after a read.");
					if (cyc - last_wr < wr_to_rd_gap)
						rule_error("Read came too soon after a write.");
					last_rd = cyc;
					last_rd_cas = int'(tim_cas);
				end else begin
					if (cyc - last_rd < rd_to_wr_gap_base + last_rd_cas)
						rule_error("Write came too soon after a read.");
					if (cyc - last_wr < wr_to_wr_gap)
						rule_error("Write came too soon after a write.");
					prev_wr = last_wr;
					last_wr = cyc;
				end
				bank_rw[cmd_bank] = cyc;
				bank_rw_wr[cmd_bank] = (cmd === cmd_write);
				bank_rw_twr[cmd_bank] = tim_wr;	// Recovery counted with the setting of the write.
				n_rw++;
				rw_cyc = cyc;
				rw_cmd = cmd;
				rw_bank = cmd_bank;
				rw_addr = cmd_addr;
			end
			if (cmd === cmd_precharge) begin
				pre_gap = bank_rw_wr[cmd_bank] ? wr_to_pre_base + int'(bank_rw_twr[cmd_bank])
					: rd_to_pre_gap;
				if (cyc - bank_rw[cmd_bank] < pre_gap)
					rule_error("Precharge came before the bank's last access had finished.");
				if (!mon_open[cmd_bank])
					rule_error("Precharge went to a bank with no open row.");
				mon_open[cmd_bank] = 1'b0;
				bank_pre[cmd_bank] = cyc;
				n_pre++;
			end
			if (cmd === cmd_activate) begin
				if (cyc - bank_pre[cmd_bank] < pre_to_act_gap)
					rule_error("Activate came too soon after the precharge.");
				if (mon_open[cmd_bank])
					rule_error("Activate went to a bank that already had an open row.");
				mon_open[cmd_bank] = 1'b1;
				mon_row[cmd_bank] = cmd_addr;
				bank_act[cmd_bank] = cyc;
				n_act++;
				act_row = cmd_addr;
			end
		end
	end

	`include "sdram_ctl_tests.svh"

	initial begin
		int b;
		void'($urandom(32'h9aa5_5a2c));	// Seeded once for the whole run.
		sdram_rst = 1'b1;
		tim_cas = 1'b0;
		tim_wr = '0;
		req = 1'b0;
		we = 1'b0;
		bank = '0;
		row = '0;
		col = '0;
		in_access = 1'b0;
		last_rd = never;
		last_rd_cas = 0;
		last_wr = never;
		prev_wr = never;
		rw_cyc = never;
		for (b = 0; b < num_banks; b++) begin
			bank_rw[b] = never;
			bank_rw_wr[b] = 1'b0;
			bank_rw_twr[b] = '0;
			bank_pre[b] = never;
			bank_act[b] = never;
			mon_open[b] = 1'b0;
			mon_row[b] = '0;
			pred_open[b] = 1'b0;
			pred_row[b] = '0;
		end
		repeat (16) @(posedge sys_clk);
		#1;
		sdram_rst = 1'b0;
		idle_after_reset();
		write_closed_bank();
		read_open_row();
		bus_turnaround();
		row_conflict();
		random_traffic();
		repeat (10) @(posedge sys_clk);
		$display("Accesses: %0d, value errors: %0d, rule errors: %0d",
			n_accesses, n_value_err, n_rule_err);
		if (n_value_err + n_rule_err == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* sdram_ctl_top.f */
+incdir+tb
rtl/sdram_timing_pkg.sv
rtl/sdram_cmd_pkg.sv
rtl/sdram_data_if.sv
rtl/sdram_bank_timer.sv
rtl/sdram_data_ctl.sv
rtl/sdram_cmd_sched.sv
rtl/sdram_ctl_top.sv
tb/sdram_ctl_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := sdram_ctl_tb
FILELIST := sdram_ctl_top.f

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
